//--- common/readout_pkg.sv
// shared widths, field constants and command codes for the trigger readout path; imported by all RTL
package readout_pkg;

  // channel and bus sizes
  localparam int num_chan    = 5;
  localparam int chan_word_w = 32;
  localparam int daq_word_w  = 64;
  localparam int dest_w      = 4;

  // reply field widths
  localparam int tag_w   = 18; // tag and fill type
  localparam int burst_w = 21;
  localparam int trig_w  = 24;
  localparam int count_w = 20; // trailer word count

  // second word of every channel readout command
  localparam logic [chan_word_w-1:0] cmd_read_code = 32'h0000_0008;

  // fixed crate header pieces
  localparam logic [chan_word_w-1:0] amc_hdr1_low  = 32'h000f_ffff; // twenty ones
  localparam logic [daq_word_w-1:0]  amc_hdr2_word = 64'h0000_0000_0000_0001;

  // marker at the top of channel header A
  localparam logic [1:0] chan_hdr_tag = 2'b01;

endpackage

//--- logic/channel_reader.sv
// reads one channel reply, holds its header fields for the formatter and packs payload pairs
`timescale 1ns/100ps

module channel_reader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                chan_start,
  input  logic [readout_pkg::chan_word_w-1:0] chan_rx_fifo_data,
  input  logic                                chan_rx_fifo_valid,
  input  logic                                hdr_taken,
  input  logic                                pair_taken,
  output logic                                chan_rx_fifo_ready,
  output logic [readout_pkg::trig_w-1:0]      trig_num,
  output logic [readout_pkg::chan_word_w-1:0] ddr_addr,
  output logic [readout_pkg::burst_w-1:0]     burst_count,
  output logic [readout_pkg::tag_w-1:0]       tag_filltype,
  output logic                                hdr_valid,
  output logic [readout_pkg::daq_word_w-1:0]  pair_data,
  output logic                                pair_valid,
  output logic                                chan_done
);
  import readout_pkg::*;

  typedef enum logic [2:0] {R_IDLE, R_HDR, R_LO, R_HI, R_PAIR} state_t;

  state_t           state;
  logic [2:0]       hdr_idx;  // reply header word index
  logic [burst_w:0] pair_cnt; // 2*burst+2 pairs per channel
  logic             rx_fire;

  assign chan_rx_fifo_ready = (state == R_HDR) || (state == R_LO) || (state == R_HI);
  assign rx_fire            = chan_rx_fifo_valid && chan_rx_fifo_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= R_IDLE;
      hdr_idx    <= '0;
      pair_cnt   <= '0;
      hdr_valid  <= 1'b0;
      pair_valid <= 1'b0;
      chan_done  <= 1'b0;
    end else begin
      chan_done <= 1'b0;
      if (hdr_taken) hdr_valid <= 1'b0;
      case (state)
        R_IDLE: begin
          if (chan_start) begin
            hdr_idx <= '0;
            state   <= R_HDR;
          end
        end
        R_HDR: begin
          if (rx_fire) begin
            hdr_idx <= hdr_idx + 3'd1;
            if (hdr_idx == 3'd5) begin
              hdr_valid <= 1'b1; // payload may be prefetched from here on
              pair_cnt  <= '0;
              state     <= R_LO;
            end
          end
        end
        R_LO: if (rx_fire) state <= R_HI;
        R_HI: begin
          if (rx_fire) begin
            pair_valid <= 1'b1;
            state      <= R_PAIR;
          end
        end
        R_PAIR: begin
          if (pair_taken) begin
            pair_valid <= 1'b0;
            if (pair_cnt == {burst_count, 1'b1}) begin
              chan_done <= 1'b1;
              state     <= R_IDLE;
            end else begin
              pair_cnt <= pair_cnt + (burst_w + 1)'(1);
              state    <= R_LO;
            end
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // reply fields and payload halves
  always_ff @(posedge clk) begin
    if (rx_fire) begin
      case (state)
        R_HDR: begin
          case (hdr_idx)
            3'd2: trig_num     <= chan_rx_fifo_data[trig_w-1:0];
            3'd3: ddr_addr     <= chan_rx_fifo_data;
            3'd4: burst_count  <= chan_rx_fifo_data[burst_w-1:0];
            3'd5: tag_filltype <= chan_rx_fifo_data[tag_w-1:0];
            default: ; // reply sequence and reply code are dropped
          endcase
        end
        R_LO:    pair_data[chan_word_w-1:0]          <= chan_rx_fifo_data; // first word low
        R_HI:    pair_data[daq_word_w-1:chan_word_w] <= chan_rx_fifo_data;
        default: ;
      endcase
    end
  end

endmodule

//--- logic/daq_formatter.sv
// builds the DAQ word stream: crate headers, channel headers, payload pairs and the event trailer
`timescale 1ns/100ps

module daq_formatter (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [readout_pkg::trig_w-1:0]      trig_num,
  input  logic [readout_pkg::chan_word_w-1:0] ddr_addr,
  input  logic [readout_pkg::burst_w-1:0]     burst_count,
  input  logic [readout_pkg::tag_w-1:0]       tag_filltype,
  input  logic                                hdr_valid,
  input  logic [readout_pkg::daq_word_w-1:0]  pair_data,
  input  logic                                pair_valid,
  input  logic                                trailer_req,
  input  logic                                daq_ready,
  output logic                                hdr_taken,
  output logic                                pair_taken,
  output logic                                trailer_done,
  output logic [readout_pkg::daq_word_w-1:0]  daq_data,
  output logic                                daq_valid,
  output logic                                daq_header,
  output logic                                daq_trailer,
  output logic                                read_fill_done
);
  import readout_pkg::*;

  typedef enum logic [2:0] {F_WAIT, F_HDR1, F_HDR2, F_CHA, F_CHB, F_PAY, F_TRL} state_t;

  state_t                state;
  logic                  first_chan;   // next channel opens the event
  logic                  trailer_pend; // request arrived while busy
  logic [count_w-1:0]    word_cnt;     // words sent this event
  logic [trig_w-1:0]     evt_trig;
  logic                  daq_fire;
  logic [daq_word_w-1:0] hdr_a_word;
  logic [daq_word_w-1:0] hdr_b_word;

  assign daq_valid      = (state != F_WAIT);
  assign daq_header     = (state == F_HDR1);
  assign daq_trailer    = (state == F_TRL);
  assign read_fill_done = (state == F_TRL);
  assign daq_fire       = daq_valid && daq_ready;
  assign hdr_taken      = (state == F_CHB) && daq_ready;
  assign pair_taken     = (state == F_WAIT) && !hdr_valid && pair_valid; // headers go first
  assign trailer_done   = (state == F_TRL) && daq_ready;

  assign hdr_a_word = {chan_hdr_tag, 12'h000, tag_filltype, 11'h000, burst_count};
  assign hdr_b_word = {6'h00, ddr_addr[25:3], 3'b000, 8'h00, trig_num}; // 8-byte aligned addr

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= F_WAIT;
      first_chan   <= 1'b1;
      trailer_pend <= 1'b0;
      word_cnt     <= '0;
      evt_trig     <= '0;
    end else begin
      if (trailer_req) trailer_pend <= 1'b1;
      if (daq_fire) word_cnt <= word_cnt + count_w'(1);
      case (state)
        F_WAIT: begin
          if (hdr_valid) begin
            evt_trig <= trig_num;
            state    <= first_chan ? F_HDR1 : F_CHA;
          end else if (pair_valid) begin
            state <= F_PAY;
          end else if (trailer_pend) begin
            trailer_pend <= 1'b0;
            state        <= F_TRL;
          end
        end
        F_HDR1: begin
          if (daq_ready) begin
            first_chan <= 1'b0;
            state      <= F_HDR2;
          end
        end
        F_HDR2: if (daq_ready) state <= F_CHA;
        F_CHA:  if (daq_ready) state <= F_CHB;
        F_CHB:  if (daq_ready) state <= F_WAIT;
        F_PAY:  if (daq_ready) state <= F_WAIT;
        F_TRL: begin
          if (daq_ready) begin
            first_chan <= 1'b1; // event closed
            word_cnt   <= '0;
            evt_trig   <= '0;
            state      <= F_WAIT;
          end
        end
        default: state <= F_WAIT;
      endcase
    end
  end

  // output word is loaded one step ahead of the state that presents it
  always_ff @(posedge clk) begin
    case (state)
      F_WAIT: begin
        if (hdr_valid) begin
          daq_data <= first_chan ? {8'h00, trig_num, amc_hdr1_low} : hdr_a_word;
        end else if (pair_valid) begin
          daq_data <= pair_data;
        end else if (trailer_pend) begin
          daq_data <= {32'h0000_0000, evt_trig[7:0], 4'h0, word_cnt + count_w'(1)};
        end
      end
      F_HDR1:  if (daq_ready) daq_data <= amc_hdr2_word;
      F_HDR2:  if (daq_ready) daq_data <= hdr_a_word;
      F_CHA:   if (daq_ready) daq_data <= hdr_b_word;
      default: ;
    endcase
  end

endmodule

//--- logic/readout_manager.sv
// top level of the trigger readout path; connects sequencer, channel reader and DAQ formatter
`timescale 1ns/100ps

module readout_manager (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [readout_pkg::num_chan-1:0]    chan_en,
  input  logic                                tm_fifo_valid,
  input  logic                                chan_tx_fifo_ready,
  input  logic [readout_pkg::chan_word_w-1:0] chan_rx_fifo_data,
  input  logic                                chan_rx_fifo_valid,
  input  logic                                chan_rx_fifo_last, // reply length comes from burst
  input  logic                                daq_ready,
  output logic                                busy,
  output logic                                tm_fifo_ready,
  output logic                                read_fill_done,
  output logic [readout_pkg::chan_word_w-1:0] chan_tx_fifo_data,
  output logic [readout_pkg::dest_w-1:0]      chan_tx_fifo_dest,
  output logic                                chan_tx_fifo_last,
  output logic                                chan_tx_fifo_valid,
  output logic                                chan_rx_fifo_ready,
  output logic [readout_pkg::daq_word_w-1:0]  daq_data,
  output logic                                daq_valid,
  output logic                                daq_header,
  output logic                                daq_trailer
);
  import readout_pkg::*;

  logic                   chan_start, chan_done, trailer_req, trailer_done;
  logic                   hdr_valid, hdr_taken, pair_valid, pair_taken;
  logic [trig_w-1:0]      trig_num;
  logic [chan_word_w-1:0] ddr_addr;
  logic [burst_w-1:0]     burst_count;
  logic [tag_w-1:0]       tag_filltype;
  logic [daq_word_w-1:0]  pair_data;

  readout_sequencer u_seq (.*);   // trigger and command side
  channel_reader    u_reader (.*); // reply side
  daq_formatter     u_fmt (.*);   // event builder side

endmodule

//--- logic/readout_sequencer.sv
// accepts triggers, scans the enabled channels and issues the two-word readout command to each
`timescale 1ns/100ps

module readout_sequencer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [readout_pkg::num_chan-1:0]    chan_en,
  input  logic                                tm_fifo_valid,
  input  logic                                chan_tx_fifo_ready,
  input  logic                                chan_done,
  input  logic                                trailer_done,
  output logic                                tm_fifo_ready,
  output logic                                busy,
  output logic [readout_pkg::chan_word_w-1:0] chan_tx_fifo_data,
  output logic [readout_pkg::dest_w-1:0]      chan_tx_fifo_dest,
  output logic                                chan_tx_fifo_last,
  output logic                                chan_tx_fifo_valid,
  output logic                                chan_start,
  output logic                                trailer_req
);
  import readout_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CHECK,     // look at the enable bit of the current destination
    S_SEND_CSN,
    S_SEND_CC,
    S_WAIT_CHAN, // reader busy with the reply
    S_WAIT_TRL
  } state_t;

  state_t                 state;
  logic [chan_word_w-1:0] seq_num; // command sequence number

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= S_IDLE;
      seq_num           <= '0;
      chan_tx_fifo_dest <= '0;
      chan_start        <= 1'b0;
      trailer_req       <= 1'b0;
    end else begin
      chan_start  <= 1'b0;
      trailer_req <= 1'b0;
      case (state)
        S_IDLE: begin
          if (tm_fifo_valid) begin
            chan_tx_fifo_dest <= '0;
            state             <= S_CHECK;
          end
        end
        S_CHECK: begin
          if (chan_tx_fifo_dest == dest_w'(num_chan)) begin
            trailer_req <= 1'b1; // past the last channel
            state       <= S_WAIT_TRL;
          end else if (chan_en[chan_tx_fifo_dest[2:0]]) begin
            state <= S_SEND_CSN;
          end else begin
            chan_tx_fifo_dest <= chan_tx_fifo_dest + dest_w'(1); // skip disabled channel
          end
        end
        S_SEND_CSN: if (chan_tx_fifo_ready) state <= S_SEND_CC;
        S_SEND_CC: begin
          if (chan_tx_fifo_ready) begin
            chan_start <= 1'b1; // reply follows on the rx port
            state      <= S_WAIT_CHAN;
          end
        end
        S_WAIT_CHAN: begin
          if (chan_done) begin
            seq_num           <= seq_num + chan_word_w'(1);
            chan_tx_fifo_dest <= chan_tx_fifo_dest + dest_w'(1);
            state             <= S_CHECK;
          end
        end
        S_WAIT_TRL: begin
          if (trailer_done) begin
            seq_num <= seq_num + chan_word_w'(1); // the trailer also takes a number
            state   <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign tm_fifo_ready      = (state == S_IDLE) && tm_fifo_valid;
  assign busy               = (state != S_IDLE);
  assign chan_tx_fifo_valid = (state == S_SEND_CSN) || (state == S_SEND_CC);
  assign chan_tx_fifo_last  = (state == S_SEND_CC);
  assign chan_tx_fifo_data  = (state == S_SEND_CC) ? cmd_read_code : seq_num;

endmodule

//--- readout_manager.f
common/readout_pkg.sv
logic/readout_sequencer.sv
logic/channel_reader.sv
logic/daq_formatter.sv
logic/readout_manager.sv
sim/readout_checker.sv
sim/readout_monitor.sv
sim/readout_manager_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the readout_manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f readout_manager.f --top-module readout_manager_tb -o sim_readout
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_readout)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- sim/readout_checker.sv
// protocol assertions on the readout_manager ports, bound into the top level
`timescale 1ns/100ps

module readout_checker (
  input logic        clk,
  input logic        rst,
  input logic [63:0] daq_data,
  input logic        daq_valid,
  input logic        daq_ready,
  input logic        daq_header,
  input logic        daq_trailer,
  input logic        tm_fifo_valid,
  input logic        tm_fifo_ready,
  input logic        chan_tx_fifo_valid,
  input logic        chan_tx_fifo_ready
);
  int fail_count = 0;

  a_daq_hold: assert property (@(posedge clk) disable iff (rst)
    daq_valid && !daq_ready |=> daq_valid && $stable(daq_data))
    else begin $error("daq word changed while stalled"); fail_count++; end

  a_flags: assert property (@(posedge clk) disable iff (rst)
    (daq_header || daq_trailer) |-> daq_valid)
    else begin $error("header or trailer flag without daq_valid"); fail_count++; end

  a_tm: assert property (@(posedge clk) disable iff (rst) tm_fifo_ready |-> tm_fifo_valid)
    else begin $error("trigger taken with no trigger pending"); fail_count++; end

  a_tx_hold: assert property (@(posedge clk) disable iff (rst)
    chan_tx_fifo_valid && !chan_tx_fifo_ready |=> chan_tx_fifo_valid)
    else begin $error("command word withdrawn before transfer"); fail_count++; end

endmodule

bind readout_manager readout_checker u_chk (.clk, .rst, .daq_data, .daq_valid, .daq_ready,
  .daq_header, .daq_trailer, .tm_fifo_valid, .tm_fifo_ready, .chan_tx_fifo_valid,
  .chan_tx_fifo_ready);

//--- sim/readout_manager_tb.sv
// testbench top for readout_manager; clock, reset, channel model and triggers from the vectors
`timescale 1ns/100ps

module readout_manager_tb;
  import readout_pkg::*;

  localparam int num_events = 14;
  localparam int vec_cols   = 21; // mask plus four values per channel

  logic                   clk                = 1'b0;
  logic                   rst                = 1'b1;
  logic [num_chan-1:0]    chan_en            = '0;
  logic                   tm_fifo_valid      = 1'b0;
  logic                   chan_tx_fifo_ready = 1'b0;
  logic [chan_word_w-1:0] chan_rx_fifo_data  = '0;
  logic                   chan_rx_fifo_valid = 1'b0;
  logic                   chan_rx_fifo_last  = 1'b0;
  logic                   daq_ready          = 1'b0;
  logic                   busy, tm_fifo_ready, read_fill_done;
  logic [chan_word_w-1:0] chan_tx_fifo_data;
  logic [dest_w-1:0]      chan_tx_fifo_dest;
  logic                   chan_tx_fifo_last, chan_tx_fifo_valid, chan_rx_fifo_ready;
  logic [daq_word_w-1:0]  daq_data;
  logic                   daq_valid, daq_header, daq_trailer;

  logic [31:0] vec [0:num_events*vec_cols-1];
  logic [31:0] rx_q [$];     // reply words waiting on the rx port
  logic [31:0] cmd_seq = '0; // sequence number of the command in flight
  logic        rx_fired = 1'b0;
  int          cur_event = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  always #50 clk = ~clk;

  readout_manager DUT (.*);
  readout_monitor mon (.*);

  // queue the reply of channel dest with header words and generated payload
  task automatic push_reply(input logic [3:0] dest, input logic [31:0] seq);
    int base;
    int burst;
    base  = cur_event*vec_cols + 1 + int'(dest)*4;
    burst = int'(vec[base+2][20:0]);
    rx_q.push_back(seq);
    rx_q.push_back(32'h0000_0001); // reply code
    for (int i = 0; i < 4; i++) rx_q.push_back(vec[base+i]);
    for (int k = 0; k < 4*burst + 4; k++) begin
      rx_q.push_back({8'(dest), 8'(cur_event), 16'(k)});
    end
  endtask

  // number of daq words in one event
  function automatic int event_words(input int e);
    int n;
    n = 1;
    for (int c = 0; c < num_chan; c++) begin
      if (vec[e*vec_cols][c]) n += 4 + 2*int'(vec[e*vec_cols + 3 + c*4][20:0]);
    end
    if (vec[e*vec_cols][num_chan-1:0] != '0) n += 2; // crate headers
    return n;
  endfunction

  // transfers seen at the rising edge
  always @(posedge clk) begin
    rx_fired = 1'b0;
    if (!rst) begin
      if (chan_tx_fifo_valid && chan_tx_fifo_ready) begin
        if (chan_tx_fifo_last) push_reply(chan_tx_fifo_dest, cmd_seq);
        else cmd_seq = chan_tx_fifo_data;
      end
      if (chan_rx_fifo_valid && chan_rx_fifo_ready) begin
        if (rx_q.size() > 0) void'(rx_q.pop_front());
        rx_fired = 1'b1;
      end
    end
  end

  // random stalls with the rx word held until taken
  always @(negedge clk) begin
    if (!rst) begin
      chan_tx_fifo_ready <= ($urandom % 4) != 0;
      daq_ready          <= ($urandom % 4) != 0;
      if (!(chan_rx_fifo_valid && !rx_fired)) begin
        chan_rx_fifo_valid <= (rx_q.size() > 0) && (($urandom % 3) != 0);
      end
      chan_rx_fifo_data <= (rx_q.size() > 0) ? rx_q[0] : '0;
      chan_rx_fifo_last <= (rx_q.size() == 1);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: event %0d not finished after %0d cycles", cur_event, cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int total;
    int errs;
    void'($urandom(32'h7a06));
    $readmemh("sim/readout_vectors.txt", vec);
    total = 0;
    for (int e = 0; e < num_events; e++) total += event_words(e);
    cycle_limit = total*20 + 200;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
    for (int e = 0; e < num_events; e++) begin
      @(negedge clk);
      cur_event     = e;
      chan_en       = vec[e*vec_cols][num_chan-1:0];
      tm_fifo_valid = 1'b1;
      @(posedge clk);
      while (!tm_fifo_ready) @(posedge clk);
      @(negedge clk);
      tm_fifo_valid = 1'b0;
      @(posedge clk);
      while (!(daq_valid && daq_ready && daq_trailer)) @(posedge clk); // event closed
    end
    repeat (10) @(posedge clk);
    errs = mon.error_count + DUT.u_chk.fail_count + mon.pending();
    $display("errors: %0d compare, %0d assertion, %0d expected words not seen",
             mon.error_count, DUT.u_chk.fail_count, mon.pending());
    if (errs == 0) $display("Result: PASSED");
    else $display("Result: FAILED");
    $finish;
  end

endmodule

//--- sim/readout_monitor.sv
// watches the readout_manager ports and compares commands, busy and DAQ words with the vector file
`timescale 1ns/100ps

module readout_monitor (
  input logic        clk,
  input logic        rst,
  input logic        busy,
  input logic        tm_fifo_ready,
  input logic        read_fill_done,
  input logic [31:0] chan_tx_fifo_data,
  input logic [3:0]  chan_tx_fifo_dest,
  input logic        chan_tx_fifo_last,
  input logic        chan_tx_fifo_valid,
  input logic        chan_tx_fifo_ready,
  input logic [63:0] daq_data,
  input logic        daq_valid,
  input logic        daq_ready,
  input logic        daq_header,
  input logic        daq_trailer
);
  localparam int num_events = 14;
  localparam int vec_cols   = 21;

  logic [31:0] vec [0:num_events*vec_cols-1];
  logic [36:0] exp_cmd [$]; // {last, dest, data}
  logic [65:0] exp_daq [$]; // {header, trailer, data}
  int          error_count = 0;
  logic        exp_busy = 1'b0;

  function automatic logic [31:0] pay_word(input int c, input int e, input int k);
    return {8'(c), 8'(e), 16'(k)};
  endfunction

  function automatic int pending();
    return exp_cmd.size() + exp_daq.size();
  endfunction

  task automatic mismatch(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    error_count++;
    $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
  endtask

  task automatic build_expected();
    int base;
    int burst;
    logic [31:0] seq;
    logic        first;
    logic [19:0] cnt;
    logic [23:0] trig;
    logic [23:0] last_trig;
    seq = '0;
    for (int e = 0; e < num_events; e++) begin
      first     = 1'b1;
      cnt       = '0;
      last_trig = '0;
      for (int c = 0; c < 5; c++) begin
        if (vec[e*vec_cols][c]) begin
          base  = e*vec_cols + 1 + c*4;
          trig  = vec[base][23:0];
          burst = int'(vec[base+2][20:0]);
          exp_cmd.push_back({1'b0, 4'(c), seq});
          exp_cmd.push_back({1'b1, 4'(c), 32'd8});
          seq = seq + 32'd1;
          if (first) begin
            exp_daq.push_back({2'b10, 8'h00, trig, 32'h000f_ffff});
            exp_daq.push_back({2'b00, 64'd1});
            cnt   = cnt + 20'd2;
            first = 1'b0;
          end
          exp_daq.push_back({2'b00, 2'b01, 12'h0, vec[base+3][17:0], 11'h0, vec[base+2][20:0]});
          exp_daq.push_back({2'b00, 6'h0, vec[base+1][25:3], 3'b000, 8'h00, trig});
          for (int k = 0; k < 2*burst + 2; k++) begin
            exp_daq.push_back({2'b00, pay_word(c, e, 2*k+1), pay_word(c, e, 2*k)});
          end
          cnt       = cnt + 20'(2*burst + 4);
          last_trig = trig;
        end
      end
      cnt = cnt + 20'd1; // trailer counts itself
      exp_daq.push_back({2'b01, 32'h0, last_trig[7:0], 4'h0, cnt});
      seq = seq + 32'd1;
    end
  endtask

  initial begin
    $readmemh("sim/readout_vectors.txt", vec);
    build_expected();
  end

  always @(posedge clk) begin
    logic [36:0] c_exp;
    logic [65:0] d_exp;
    if (rst) begin
      exp_busy = 1'b0;
    end else begin
      if (busy !== exp_busy) mismatch("busy", 64'(exp_busy), 64'(busy));
      if (tm_fifo_ready) exp_busy = 1'b1;
      if (daq_valid && daq_ready && daq_trailer) exp_busy = 1'b0;
      if (chan_tx_fifo_valid && chan_tx_fifo_ready) begin
        if (exp_cmd.size() == 0) begin
          error_count++;
          $display("command word sent to channel %0d when none was expected", chan_tx_fifo_dest);
        end else begin
          c_exp = exp_cmd.pop_front();
          if (chan_tx_fifo_data !== c_exp[31:0])
            mismatch("chan_tx_fifo_data", 64'(c_exp[31:0]), 64'(chan_tx_fifo_data));
          if (chan_tx_fifo_dest !== c_exp[35:32])
            mismatch("chan_tx_fifo_dest", 64'(c_exp[35:32]), 64'(chan_tx_fifo_dest));
          if (chan_tx_fifo_last !== c_exp[36])
            mismatch("chan_tx_fifo_last", 64'(c_exp[36]), 64'(chan_tx_fifo_last));
        end
      end
      if (daq_valid && daq_ready) begin
        if (exp_daq.size() == 0) begin
          error_count++;
          $display("extra DAQ word %h sent after the last expected word", daq_data);
        end else begin
          d_exp = exp_daq.pop_front();
          if (daq_data !== d_exp[63:0]) mismatch("daq_data", d_exp[63:0], daq_data);
          if (daq_header !== d_exp[65]) mismatch("daq_header", 64'(d_exp[65]), 64'(daq_header));
          if (daq_trailer !== d_exp[64])
            mismatch("daq_trailer", 64'(d_exp[64]), 64'(daq_trailer));
          if (read_fill_done !== d_exp[64])
            mismatch("read_fill_done", 64'(d_exp[64]), 64'(read_fill_done));
        end
      end
    end
  end

endmodule

//--- sim/readout_vectors.txt
// mask, then for channels 0 to 4: trigger address burst tag (all hex)
// payload words are generated by the channel model from channel, event and word index
1f 000011 00001000 1 00101 000011 00002008 1 00102 000011 00003010 1 00103 000011 00004018 1 00104 000011 00005020 1 00105
00 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000
01 000a21 0fabcdef 0 3ffff 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000
10 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 123456 03fffff8 2 2aaaa
15 000b01 00000040 2 00011 000000 00000000 0 00000 000b01 00000080 0 00012 000000 00000000 0 00000 000b01 000000c7 1 00013
0a 000000 00000000 0 00000 00c0de 10000100 1 1f00f 000000 00000000 0 00000 00c0de 20000200 2 1f010 000000 00000000 0 00000
1f 0000ff 00000008 0 00001 0000ff 00000010 0 00002 0000ff 00000018 0 00003 0000ff 00000020 0 00004 0000ff 00000028 0 00005
03 abcdef 00fedcb8 2 15555 abcdef 00123450 1 0aaaa 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000
18 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 fffffe 01010108 1 00777 fffffe 02020208 0 00778
00 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000
04 000000 00000000 0 00000 000000 00000000 0 00000 700001 3ffffff8 2 3fffe 000000 00000000 0 00000 000000 00000000 0 00000
11 000102 00000300 1 00aa0 000000 00000000 0 00000 000000 00000000 0 00000 000000 00000000 0 00000 000102 00000308 1 00aa1
0e 000000 00000000 0 00000 000203 00000400 0 00bb0 000203 00000408 1 00bb1 000203 00000410 2 00bb2 000000 00000000 0 00000
1f 00ffee 00010000 2 11111 00ffee 00020000 1 22222 00ffee 00030000 0 33333 00ffee 00040000 1 01234 00ffee 00050000 2 04321
